//--- source/slice_consts.svh
/*
 * size and latency constants for the execution slice
 * reorder buffer depth, unit count, datapath widths, op latencies
 */

`ifndef SLICE_CONSTS_SVH
`define SLICE_CONSTS_SVH

// reorder buffer geometry
// depth must stay a power of two so the pointers wrap on their own
`define ROB_DEPTH     8
`define ROB_TAG_BITS  3

// execution resources
`define NUM_UNITS     3

// datapath widths
`define DATA_WIDTH    16
`define REG_BITS      4

// cycles from issue strobe to done
`define MUL_LATENCY   4
`define ALU_LATENCY   1

`endif

//--- source/slice_pkg.sv
/*
 * shared types for the execution slice
 * value, tag, pointer and register vectors, op codes, state enums
 */

`include "slice_consts.svh"

package slice_pkg;

    //////////////////////////////////////////////////////////////////////
    // vector types
    //////////////////////////////////////////////////////////////////////

    // operand or result value
    typedef logic [`DATA_WIDTH-1:0]     data_t;

    // slot index into the reorder buffer
    typedef logic [`ROB_TAG_BITS-1:0]   rob_tag_t;

    // slot index with the wrap bit on top
    typedef logic [`ROB_TAG_BITS:0]     rob_ptr_t;

    // architectural destination register
    typedef logic [`REG_BITS-1:0]       reg_idx_t;

    // one bit per execution unit
    typedef logic [`NUM_UNITS-1:0]      unit_mask_t;

    // op codes
    typedef logic [1:0] op_t;

    localparam op_t op_add = 2'd0;
    localparam op_t op_sub = 2'd1;
    localparam op_t op_xor = 2'd2;
    localparam op_t op_mul = 2'd3;

    //////////////////////////////////////////////////////////////////////
    // state machines
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {idle, running, finished} unit_state_t;

    typedef enum logic [1:0] {empty, waiting, ready} entry_state_t;

endpackage

//--- source/exec_if.sv
/*
 * issue_if, dispatch to one execution unit
 * complete_if, one execution unit to the completion arbiter
 */

`timescale 1ns/1ps

// valid is a one-cycle strobe, only while busy is low
// busy goes high the cycle after and stays up until the grant
interface issue_if
    import slice_pkg::*;
();
    logic     valid;
    rob_tag_t tag;
    op_t      op;
    data_t    a;
    data_t    b;
    logic     busy;

    modport sender   (output valid, tag, op, a, b, input busy);
    modport receiver (input valid, tag, op, a, b, output busy);
endinterface

// done is a level, tag and value held until a one-cycle grant
// the unit drops done on the edge after the grant
interface complete_if
    import slice_pkg::*;
();
    logic     done;
    rob_tag_t tag;
    data_t    value;
    logic     grant;

    modport producer (output done, tag, value, input grant);
    modport consumer (input done, tag, value, output grant);
endinterface

//--- source/dispatch_unit.sv
/*
 * dispatch stage
 * takes in-order instructions, picks the lowest free unit,
 * registers the issue strobe and the reorder buffer allocation
 */

`timescale 1ns/1ps

`include "slice_consts.svh"

module dispatch_unit
    import slice_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       flush,
    input  logic       instr_valid,
    input  op_t        instr_op,
    input  data_t      instr_a,
    input  data_t      instr_b,
    input  reg_idx_t   instr_dest,
    input  rob_tag_t   alloc_tag,
    input  logic       rob_full,
    output logic       alloc,
    output reg_idx_t   alloc_dest,
    output logic       dispatch_ready,
    issue_if.sender    issue [`NUM_UNITS]
);

    unit_mask_t busy_mask;
    unit_mask_t free_mask;
    unit_mask_t pick;
    unit_mask_t strobe_q;
    logic       any_free;
    logic       accept;

    // shared issue payload, only the picked unit sees valid
    rob_tag_t   tag_q;
    op_t        op_q;
    data_t      a_q;
    data_t      b_q;

    //////////////////////////////////////////////////////////////////////
    // unit selection
    //////////////////////////////////////////////////////////////////////

    // a unit strobed last cycle has not raised busy yet, so mask it too
    assign free_mask = ~busy_mask & ~strobe_q;

    // priority encoder, lowest free unit wins
    always_comb begin
        pick     = '0;
        any_free = 1'b0;
        for (int i = `NUM_UNITS - 1; i >= 0; i--) begin
            if (free_mask[i]) begin
                pick     = unit_mask_t'(1) << i;
                any_free = 1'b1;
            end
        end
    end

    assign dispatch_ready = !rob_full && any_free;

    // flush wins over a new instruction in the same cycle
    assign accept = instr_valid && dispatch_ready && !flush;

    //////////////////////////////////////////////////////////////////////
    // registered issue and allocation
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            strobe_q <= '0;
            alloc    <= 1'b0;
        end else begin
            strobe_q <= accept ? pick : '0;
            alloc    <= accept;
        end
    end

    // payload only matters alongside a strobe
    always_ff @(posedge clock) begin
        if (accept) begin
            tag_q      <= alloc_tag;
            op_q       <= instr_op;
            a_q        <= instr_a;
            b_q        <= instr_b;
            alloc_dest <= instr_dest;
        end
    end

    // fan out to the unit interfaces
    for (genvar g = 0; g < `NUM_UNITS; g++) begin : g_issue
        assign busy_mask[g]   = issue[g].busy;
        assign issue[g].valid = strobe_q[g];
        assign issue[g].tag   = tag_q;
        assign issue[g].op    = op_q;
        assign issue[g].a     = a_q;
        assign issue[g].b     = b_q;

        // an issue strobe must never land on a unit that is still working
        a_no_issue_to_busy: assert property (
            @(posedge clock) disable iff (reset)
            issue[g].valid |-> !issue[g].busy
        ) else $error("issue strobe to busy unit %0d", g);
    end

endmodule

//--- source/exec_unit.sv
/*
 * one execution unit
 * computes add, sub, xor or mul at issue, counts down the op latency,
 * then holds tag and result until the arbiter grants it
 */

`timescale 1ns/1ps

`include "slice_consts.svh"

module exec_unit
    import slice_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         flush,
    issue_if.receiver    issue,
    complete_if.producer complete
);

    // counter wide enough for the longest op
    localparam int CNT_BITS = $clog2(`MUL_LATENCY + 1);

    unit_state_t         state;
    logic [CNT_BITS-1:0] count_q;
    rob_tag_t            tag_q;
    data_t               value_q;

    // add and sub wrap, mul keeps the low half
    function automatic data_t alu_result(input op_t op, input data_t a, input data_t b);
        data_t r;
        case (op)
            op_add:  r = a + b;
            op_sub:  r = a - b;
            op_xor:  r = a ^ b;
            default: r = a * b;
        endcase
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // control FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state   <= idle;
            count_q <= '0;
        end else if (flush) begin
            // drop whatever is in flight, including a same-cycle issue
            state   <= idle;
            count_q <= '0;
        end else begin
            case (state)
                idle: begin
                    if (issue.valid) begin
                        state   <= running;
                        count_q <= (issue.op == op_mul) ? CNT_BITS'(`MUL_LATENCY - 1)
                                                        : CNT_BITS'(`ALU_LATENCY - 1);
                    end
                end
                running: begin
                    if (count_q == '0) begin
                        state <= finished;
                    end else begin
                        count_q <= count_q - 1'b1;
                    end
                end
                finished: begin
                    // hold until the arbiter takes the result
                    if (complete.grant) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // result is known at issue, it only waits out the latency
    always_ff @(posedge clock) begin
        if (state == idle && issue.valid) begin
            tag_q   <= issue.tag;
            value_q <= alu_result(issue.op, issue.a, issue.b);
        end
    end

    assign issue.busy     = (state != idle);
    assign complete.done  = (state == finished);
    assign complete.tag   = tag_q;
    assign complete.value = value_q;

    a_done_drops_after_grant: assert property (
        @(posedge clock) disable iff (reset)
        complete.grant |=> !complete.done
    ) else $error("done still high after grant");

endmodule

//--- source/completion_arbiter.sv
/*
 * completion arbiter
 * fixed priority, lowest unit index first, one result per cycle
 * onto the registered result bus
 */

`timescale 1ns/1ps

`include "slice_consts.svh"

module completion_arbiter
    import slice_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    complete_if.consumer complete [`NUM_UNITS],
    output logic         cdb_valid,
    output rob_tag_t     cdb_tag,
    output data_t        cdb_value
);

    unit_mask_t done_mask;
    unit_mask_t grant_mask;
    rob_tag_t   unit_tag   [`NUM_UNITS];
    data_t      unit_value [`NUM_UNITS];
    rob_tag_t   sel_tag;
    data_t      sel_value;

    // gather the unit interfaces into plain arrays
    for (genvar g = 0; g < `NUM_UNITS; g++) begin : g_gather
        assign done_mask[g]      = complete[g].done;
        assign unit_tag[g]       = complete[g].tag;
        assign unit_value[g]     = complete[g].value;
        assign complete[g].grant = grant_mask[g];
    end

    // isolate the lowest set bit
    assign grant_mask = done_mask & (~done_mask + 1'b1);

    // one-hot select of the granted payload
    always_comb begin
        sel_tag   = '0;
        sel_value = '0;
        for (int i = 0; i < `NUM_UNITS; i++) begin
            if (grant_mask[i]) begin
                sel_tag   = unit_tag[i];
                sel_value = unit_value[i];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // result bus register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= |done_mask;
        end
    end

    always_ff @(posedge clock) begin
        cdb_tag   <= sel_tag;
        cdb_value <= sel_value;
    end

endmodule

//--- source/reorder_buffer.sv
/*
 * reorder buffer
 * circular entries with empty, waiting and ready status,
 * allocation at tail, result bus writeback, in-order retire at head,
 * flush and full flag
 */

`timescale 1ns/1ps

`include "slice_consts.svh"

module reorder_buffer
    import slice_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     flush,
    input  logic     alloc,
    input  reg_idx_t alloc_dest,
    output rob_tag_t alloc_tag,
    output logic     rob_full,
    input  logic     cdb_valid,
    input  rob_tag_t cdb_tag,
    input  data_t    cdb_value,
    input  logic     retire_enable,
    output logic     retire_valid,
    output rob_tag_t retire_tag,
    output reg_idx_t retire_dest,
    output data_t    retire_value
);

    entry_state_t status    [`ROB_DEPTH];
    reg_idx_t     dest_mem  [`ROB_DEPTH];
    data_t        value_mem [`ROB_DEPTH];

    // pointers carry a wrap bit above the slot index
    rob_ptr_t head;
    rob_ptr_t tail;
    rob_ptr_t tail_next;
    rob_ptr_t occupancy;
    rob_tag_t head_slot;
    rob_tag_t tail_slot;

    logic is_full;
    logic alloc_ok;
    logic cdb_hit;
    logic retire_fire;

    assign head_slot = head[`ROB_TAG_BITS-1:0];
    assign tail_slot = tail[`ROB_TAG_BITS-1:0];

    //////////////////////////////////////////////////////////////////////
    // occupancy and lookahead
    //////////////////////////////////////////////////////////////////////

    // same slot, other lap
    assign is_full   = (head_slot == tail_slot) && (head[`ROB_TAG_BITS] != tail[`ROB_TAG_BITS]);
    assign occupancy = tail - head;
    assign alloc_ok  = alloc && !is_full;
    assign tail_next = tail + rob_ptr_t'(alloc_ok);

    // dispatch registers its request one cycle before we see it,
    // so tag and full already account for an alloc in flight
    assign alloc_tag = tail_next[`ROB_TAG_BITS-1:0];
    assign rob_full  = is_full || (alloc && occupancy == rob_ptr_t'(`ROB_DEPTH - 1));

    // stale results after a flush land on empty entries and are dropped
    assign cdb_hit     = cdb_valid && !flush && (status[cdb_tag] == waiting);
    assign retire_fire = retire_enable && !flush && (status[head_slot] == ready);

    //////////////////////////////////////////////////////////////////////
    // control state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                status[i] <= empty;
            end
            head         <= '0;
            tail         <= '0;
            retire_valid <= 1'b0;
        end else if (flush) begin
            // a pending alloc still consumes its tag, then everything empties
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                status[i] <= empty;
            end
            tail         <= tail_next;
            head         <= tail_next;
            retire_valid <= 1'b0;
        end else begin
            if (alloc_ok) begin
                status[tail_slot] <= waiting;
            end
            if (cdb_hit) begin
                status[cdb_tag] <= ready;
            end
            if (retire_fire) begin
                status[head_slot] <= empty;
                head              <= head + 1'b1;
            end
            tail         <= tail_next;
            retire_valid <= retire_fire;
        end
    end

    // entry payload and retire outputs
    always_ff @(posedge clock) begin
        if (alloc_ok && !flush) begin
            dest_mem[tail_slot] <= alloc_dest;
        end
        if (cdb_hit) begin
            value_mem[cdb_tag] <= cdb_value;
        end
        if (retire_fire) begin
            retire_tag   <= head_slot;
            retire_dest  <= dest_mem[head_slot];
            retire_value <= value_mem[head_slot];
        end
    end

    a_no_alloc_when_full: assert property (
        @(posedge clock) disable iff (reset)
        alloc |-> !is_full
    ) else $error("allocation while reorder buffer full");

    // a grant taken during the flush cycle may still show up once
    a_cdb_hits_live_entry: assert property (
        @(posedge clock) disable iff (reset)
        (cdb_valid && !flush && !$past(flush)) |-> (status[cdb_tag] != empty)
    ) else $error("result bus targets empty entry %0d", cdb_tag);

endmodule

//--- source/exec_slice.sv
/*
 * execution slice top level
 * dispatch, three execution units, completion arbiter, reorder buffer
 */

`timescale 1ns/1ps

`include "slice_consts.svh"

module exec_slice
    import slice_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     instr_valid,
    input  op_t      instr_op,
    input  data_t    instr_a,
    input  data_t    instr_b,
    input  reg_idx_t instr_dest,
    input  logic     retire_enable,
    input  logic     flush,
    output logic     dispatch_ready,
    output logic     retire_valid,
    output rob_tag_t retire_tag,
    output reg_idx_t retire_dest,
    output data_t    retire_value
);

    // allocation link
    logic     alloc;
    reg_idx_t alloc_dest;
    rob_tag_t alloc_tag;
    logic     rob_full;

    // result bus
    logic     cdb_valid;
    rob_tag_t cdb_tag;
    data_t    cdb_value;

    issue_if    issue_bus    [`NUM_UNITS] ();
    complete_if complete_bus [`NUM_UNITS] ();

    dispatch_unit i_dispatch (
        .clock          (clock),
        .reset          (reset),
        .flush          (flush),
        .instr_valid    (instr_valid),
        .instr_op       (instr_op),
        .instr_a        (instr_a),
        .instr_b        (instr_b),
        .instr_dest     (instr_dest),
        .alloc_tag      (alloc_tag),
        .rob_full       (rob_full),
        .alloc          (alloc),
        .alloc_dest     (alloc_dest),
        .dispatch_ready (dispatch_ready),
        .issue          (issue_bus)
    );

    for (genvar g = 0; g < `NUM_UNITS; g++) begin : g_unit
        exec_unit i_exec (
            .clock    (clock),
            .reset    (reset),
            .flush    (flush),
            .issue    (issue_bus[g]),
            .complete (complete_bus[g])
        );
    end

    completion_arbiter i_arbiter (
        .clock     (clock),
        .reset     (reset),
        .complete  (complete_bus),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value)
    );

    reorder_buffer i_rob (
        .clock         (clock),
        .reset         (reset),
        .flush         (flush),
        .alloc         (alloc),
        .alloc_dest    (alloc_dest),
        .alloc_tag     (alloc_tag),
        .rob_full      (rob_full),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value),
        .retire_enable (retire_enable),
        .retire_valid  (retire_valid),
        .retire_tag    (retire_tag),
        .retire_dest   (retire_dest),
        .retire_value  (retire_value)
    );

endmodule

//--- sim/tb_exec_slice.sv
/*
 * testbench for the execution slice
 * table of instructions applied in a loop, in-order reference queue,
 * retire monitor, compare tasks and a watchdog
 */

`timescale 1ns/1ps

module tb_exec_slice
    import slice_pkg::*;
();

    // one table row, either an instruction, a flush or a drain point
    typedef struct {
        op_t      op;
        data_t    a;
        data_t    b;
        reg_idx_t dest;
        logic     ren;
        logic     is_flush;
        logic     is_drain;
        logic     want_stall;
    } row_t;

    // what the next retire must look like
    typedef struct {
        rob_tag_t tag;
        reg_idx_t dest;
        data_t    value;
    } pending_t;

    logic     clock;
    logic     reset;
    logic     instr_valid;
    op_t      instr_op;
    data_t    instr_a;
    data_t    instr_b;
    reg_idx_t instr_dest;
    logic     retire_enable;
    logic     flush;
    logic     dispatch_ready;
    logic     retire_valid;
    rob_tag_t retire_tag;
    reg_idx_t retire_dest;
    data_t    retire_value;

    row_t     table_q [$];
    pending_t pending_q [$];
    rob_tag_t next_tag;
    logic     enable_at_edge;
    integer   seed;
    int       value_errors;
    int       tag_errors;
    int       dest_errors;
    int       other_errors;

    exec_slice i_dut (
        .clock          (clock),
        .reset          (reset),
        .instr_valid    (instr_valid),
        .instr_op       (instr_op),
        .instr_a        (instr_a),
        .instr_b        (instr_b),
        .instr_dest     (instr_dest),
        .retire_enable  (retire_enable),
        .flush          (flush),
        .dispatch_ready (dispatch_ready),
        .retire_valid   (retire_valid),
        .retire_tag     (retire_tag),
        .retire_dest    (retire_dest),
        .retire_value   (retire_value)
    );

    always #10 clock = ~clock;

    // retire_enable as the DUT saw it at the last edge
    always @(posedge clock) begin
        enable_at_edge <= retire_enable;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model and compare tasks
    //////////////////////////////////////////////////////////////////////

    // results are taken modulo 2^16 from a 32 bit computation
    function automatic data_t expected_result(input op_t op, input data_t a, input data_t b);
        logic [31:0] wide;
        case (op)
            op_add:  wide = {16'h0, a} + {16'h0, b};
            op_sub:  wide = {16'h0, a} - {16'h0, b};
            op_xor:  wide = {16'h0, a ^ b};
            default: wide = {16'h0, a} * {16'h0, b};
        endcase
        return wide[15:0];
    endfunction

    task automatic check_value(input string name, input data_t actual, input data_t wanted);
        if (actual !== wanted) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, actual, wanted);
            value_errors++;
        end
    endtask

    task automatic check_tag(input string name, input rob_tag_t actual, input rob_tag_t wanted);
        if (actual !== wanted) begin
            $display("Error at %0t: %s is %0d, expected %0d", $time, name, actual, wanted);
            tag_errors++;
        end
    endtask

    task automatic check_dest(input string name, input reg_idx_t actual, input reg_idx_t wanted);
        if (actual !== wanted) begin
            $display("Error at %0t: %s is %0d, expected %0d", $time, name, actual, wanted);
            dest_errors++;
        end
    endtask

    // every retire pops the oldest dispatched instruction
    always @(negedge clock) begin : retire_monitor
        pending_t p;
        if (!reset && retire_valid) begin
            if (!enable_at_edge) begin
                $display("retire_valid at %0t although retire_enable was low", $time);
                other_errors++;
            end
            if (pending_q.size() == 0) begin
                $display("retire_valid at %0t with no instruction outstanding", $time);
                other_errors++;
            end else begin
                p = pending_q.pop_front();
                check_tag("retire_tag", retire_tag, p.tag);
                check_dest("retire_dest", retire_dest, p.dest);
                check_value("retire_value", retire_value, p.value);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // table building
    //////////////////////////////////////////////////////////////////////

    task automatic instr_row(input op_t op, input data_t a, input data_t b,
                             input reg_idx_t dest, input logic ren, input logic want_stall);
        row_t r;
        r.op         = op;
        r.a          = a;
        r.b          = b;
        r.dest       = dest;
        r.ren        = ren;
        r.is_flush   = 1'b0;
        r.is_drain   = 1'b0;
        r.want_stall = want_stall;
        table_q.push_back(r);
    endtask

    task automatic flush_row(input logic ren);
        row_t r;
        r          = '{default: '0};
        r.ren      = ren;
        r.is_flush = 1'b1;
        table_q.push_back(r);
    endtask

    task automatic drain_row();
        row_t r;
        r          = '{default: '0};
        r.ren      = 1'b1;
        r.is_drain = 1'b1;
        table_q.push_back(r);
    endtask

    task automatic build_table();
        data_t ra;
        data_t rb;
        // every op once, wraparound cases included
        instr_row(op_add, 16'hffff, 16'h0002, 4'd1, 1'b1, 1'b0);
        instr_row(op_sub, 16'h0003, 16'h0005, 4'd2, 1'b1, 1'b0);
        instr_row(op_xor, 16'ha5a5, 16'h0ff0, 4'd3, 1'b1, 1'b0);
        instr_row(op_mul, 16'h1234, 16'h0100, 4'd4, 1'b1, 1'b0);
        instr_row(op_mul, 16'hffff, 16'hffff, 4'd5, 1'b1, 1'b0);
        for (int k = 0; k < 4; k++) begin
            ra = data_t'($random(seed));
            rb = data_t'($random(seed));
            instr_row(op_t'(k), ra, rb, reg_idx_t'(10 + k), 1'b1, 1'b0);
        end
        // a slow mul ahead of fast adds
        drain_row();
        instr_row(op_mul, 16'h0007, 16'h0009, 4'd6, 1'b1, 1'b0);
        instr_row(op_add, 16'h0100, 16'h0001, 4'd7, 1'b1, 1'b0);
        instr_row(op_add, 16'h0200, 16'h0002, 4'd8, 1'b1, 1'b0);
        instr_row(op_add, 16'h0300, 16'h0003, 4'd9, 1'b1, 1'b0);
        // fill all eight entries with retire held off
        drain_row();
        for (int k = 0; k < 8; k++) begin
            ra = data_t'($random(seed));
            rb = data_t'($random(seed));
            instr_row(op_t'(k % 3), ra, rb, reg_idx_t'(k), 1'b0, 1'b0);
        end
        instr_row(op_sub, 16'h1000, 16'h0001, 4'd15, 1'b1, 1'b1);
        // three muls take every unit
        drain_row();
        instr_row(op_mul, 16'h0011, 16'h0003, 4'd1, 1'b1, 1'b0);
        instr_row(op_mul, 16'h0101, 16'h0101, 4'd2, 1'b1, 1'b0);
        instr_row(op_mul, 16'h8000, 16'h0003, 4'd3, 1'b1, 1'b0);
        instr_row(op_add, 16'h0040, 16'h0004, 4'd4, 1'b1, 1'b1);
        // flush with work in flight, then new work
        drain_row();
        instr_row(op_mul, 16'h0033, 16'h0002, 4'd5, 1'b0, 1'b0);
        instr_row(op_add, 16'h0044, 16'h0001, 4'd6, 1'b0, 1'b0);
        instr_row(op_mul, 16'h0055, 16'h0003, 4'd7, 1'b0, 1'b0);
        flush_row(1'b1);
        instr_row(op_add, 16'h7fff, 16'h0001, 4'd8, 1'b1, 1'b0);
        instr_row(op_sub, 16'h0000, 16'h0001, 4'd9, 1'b1, 1'b0);
        instr_row(op_mul, 16'h0abc, 16'h0010, 4'd10, 1'b1, 1'b0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // row application
    //////////////////////////////////////////////////////////////////////

    // called 2 ns after an edge, returns 2 ns after an edge
    task automatic dispatch_one(input int idx);
        row_t     r;
        pending_t p;
        logic     stalled;
        r             = table_q[idx];
        stalled       = 1'b0;
        retire_enable = r.ren;
        while (!dispatch_ready) begin
            stalled = 1'b1;
            @(posedge clock);
            #2;
        end
        instr_valid = 1'b1;
        instr_op    = r.op;
        instr_a     = r.a;
        instr_b     = r.b;
        instr_dest  = r.dest;
        p.tag       = next_tag;
        p.dest      = r.dest;
        p.value     = expected_result(r.op, r.a, r.b);
        pending_q.push_back(p);
        next_tag    = next_tag + 1'b1;
        @(posedge clock);
        #2;
        instr_valid = 1'b0;
        if (r.want_stall && !stalled) begin
            $display("dispatch_ready never dropped before row %0d", idx);
            other_errors++;
        end
    endtask

    // the tag counter keeps running, tail already covers every dispatch
    task automatic apply_flush(input logic ren);
        retire_enable = ren;
        flush         = 1'b1;
        @(posedge clock);
        #2;
        flush = 1'b0;
        pending_q.delete();
        // quiet window, any retire here is a leftover
        repeat (8) @(posedge clock);
        #2;
    endtask

    task automatic wait_drained();
        retire_enable = 1'b1;
        while (pending_q.size() != 0) begin
            @(posedge clock);
            #2;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed           = 32'h9f5eb280;
        clock          = 1'b0;
        reset          = 1'b1;
        instr_valid    = 1'b0;
        instr_op       = op_add;
        instr_a        = '0;
        instr_b        = '0;
        instr_dest     = '0;
        retire_enable  = 1'b0;
        flush          = 1'b0;
        enable_at_edge = 1'b0;
        next_tag       = '0;
        value_errors   = 0;
        tag_errors     = 0;
        dest_errors    = 0;
        other_errors   = 0;
        build_table();

        repeat (3) @(posedge clock);
        #2;
        reset = 1'b0;
        @(posedge clock);
        #2;
        if (dispatch_ready !== 1'b1) begin
            $display("dispatch_ready is not high after reset");
            other_errors++;
        end
        if (retire_valid !== 1'b0) begin
            $display("retire_valid is not low after reset");
            other_errors++;
        end

        foreach (table_q[i]) begin
            if (table_q[i].is_flush) begin
                apply_flush(table_q[i].ren);
            end else if (table_q[i].is_drain) begin
                wait_drained();
            end else begin
                dispatch_one(i);
            end
        end
        wait_drained();
        repeat (10) @(posedge clock);

        $display("error counts: value %0d, tag %0d, dest %0d, other %0d",
                 value_errors, tag_errors, dest_errors, other_errors);
        if (value_errors + tag_errors + dest_errors + other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // 20 cycles per table row is far more than any row needs
    initial begin : watchdog
        wait (table_q.size() > 0);
        #(table_q.size() * 20 * 20);
        $display("timeout: the run did not finish within %0d rows of 20 cycles", table_q.size());
        $display("error counts: value %0d, tag %0d, dest %0d, other %0d",
                 value_errors, tag_errors, dest_errors, other_errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- exec_slice.f
+incdir+source
source/slice_pkg.sv
source/exec_if.sv
source/dispatch_unit.sv
source/exec_unit.sv
source/completion_arbiter.sv
source/reorder_buffer.sv
source/exec_slice.sv
sim/tb_exec_slice.sv

//--- Bender.yml
package:
  name: exec_slice

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/slice_pkg.sv
      - source/exec_if.sv
      - source/dispatch_unit.sv
      - source/exec_unit.sv
      - source/completion_arbiter.sv
      - source/reorder_buffer.sv
      - source/exec_slice.sv
  - target: test
    files:
      - sim/tb_exec_slice.sv
